/* hw/couple_pkg.sv */
package couple_pkg;

	// Width of the drive samples, the coupling magnitudes and the CORDIC x/y values
	localparam int data_w = 18;

	// LO phase and phase offsets, where 2**phase_w counts as one full turn
	localparam int phase_w = 19;

	// Coupled output keeps one extra MSB from the final subtraction
	localparam int pair_w = data_w + 1;

	// Number of unrolled CORDIC stages
	localparam int cordic_stages = 20;

	// Which half of the I/Q interleave the current cycle carries
	// The encoding matches the iq input, high on I cycles
	typedef enum logic {
		slot_q = 1'b0,
		slot_i = 1'b1
	} iq_slot_t;

endpackage

/* hw/host_pkg.sv */
package host_pkg;

	// Host bus widths
	localparam int host_addr_w = 3;
	localparam int host_data_w = 19;

	// Register map seen by the host
	// Couplings are indexed by slot, so index 1 serves the I cycles
	typedef enum logic [host_addr_w-1:0] {
		reg_coupling_0 = 3'd0,
		reg_coupling_1 = 3'd1,
		reg_offset_0   = 3'd2,
		reg_offset_1   = 3'd3,
		reg_lo_step    = 3'd4,
		// Write-only strobe that clears the LO phase
		reg_lo_reset   = 3'd5
	} reg_addr_t;

endpackage

/* hw/cordic_rotator.sv */
module cordic_rotator #(
	parameter int stages = 20,
	parameter int width = 18
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic signed [width-1:0]          xin,
	input  logic signed [width-1:0]          yin,
	input  logic [couple_pkg::phase_w-1:0]   phasein,
	output logic signed [width-1:0]          xout,
	output logic signed [width-1:0]          yout
);
	import couple_pkg::*;

	// Two guard bits absorb the CORDIC gain inside the pipeline
	localparam int guard = 2;
	localparam int xw = width + guard;
	// Residual angle in units of 2**(phase_w+2) per turn, plus a sign bit
	localparam int zw = phase_w + 3;

	// Arctangent of 2**-idx is scaled to 2**21 counts per full turn
	// Entries past the table end are zero and leave the angle alone
	function automatic logic signed [zw-1:0] atan_lut(input int idx);
		case (idx)
			0:  atan_lut = zw'(262144);
			1:  atan_lut = zw'(154753);
			2:  atan_lut = zw'(81767);
			3:  atan_lut = zw'(41506);
			4:  atan_lut = zw'(20834);
			5:  atan_lut = zw'(10427);
			6:  atan_lut = zw'(5215);
			7:  atan_lut = zw'(2608);
			8:  atan_lut = zw'(1304);
			9:  atan_lut = zw'(652);
			10: atan_lut = zw'(326);
			11: atan_lut = zw'(163);
			12: atan_lut = zw'(81);
			13: atan_lut = zw'(41);
			14: atan_lut = zw'(20);
			15: atan_lut = zw'(10);
			16: atan_lut = zw'(5);
			17: atan_lut = zw'(3);
			18: atan_lut = zw'(1);
			19: atan_lut = zw'(1);
			default: atan_lut = '0;
		endcase
	endfunction

	// Per-stage vector and residual angle
	// The final stage has no use for its angle, so z stops one short
	logic signed [xw-1:0] x [0:stages];
	logic signed [xw-1:0] y [0:stages];
	logic signed [zw-1:0] z [0:stages-1];

	// The top two phase bits pick a quadrant and the rest stays below 90 degrees
	logic [1:0] quad;
	logic signed [zw-1:0] resid;
	logic signed [xw-1:0] xe;
	logic signed [xw-1:0] ye;

	assign quad = phasein[phase_w-1 -: 2];
	assign resid = zw'({phasein[phase_w-3:0], 2'b00});
	// Sign extension first, so negating the most negative input cannot wrap
	assign xe = xw'(xin);
	assign ye = xw'(yin);

	// Pre-rotation by a whole number of quarter turns
	always_ff @(posedge clk) begin
		if (rst) begin
			x[0] <= '0;
			y[0] <= '0;
			z[0] <= '0;
		end else begin
			case (quad)
				2'd0: begin
					x[0] <= xe;
					y[0] <= ye;
				end
				2'd1: begin
					x[0] <= -ye;
					y[0] <= xe;
				end
				2'd2: begin
					x[0] <= -xe;
					y[0] <= -ye;
				end
				default: begin
					x[0] <= ye;
					y[0] <= -xe;
				end
			endcase
			z[0] <= resid;
		end
	end

	// One micro-rotation per clock, steered by the sign of the residual angle
	for (genvar i = 0; i < stages; i++) begin : g_stage
		always_ff @(posedge clk) begin
			if (rst) begin
				x[i+1] <= '0;
				y[i+1] <= '0;
			end else if (z[i] < 0) begin
				// Clockwise step
				x[i+1] <= x[i] + (y[i] >>> i);
				y[i+1] <= y[i] - (x[i] >>> i);
			end else begin
				// Counterclockwise step
				x[i+1] <= x[i] - (y[i] >>> i);
				y[i+1] <= y[i] + (x[i] >>> i);
			end
		end

		if (i < stages - 1) begin : g_angle
			always_ff @(posedge clk) begin
				if (rst) begin
					z[i+1] <= '0;
				end else if (z[i] < 0) begin
					z[i+1] <= z[i] + atan_lut(i);
				end else begin
					z[i+1] <= z[i] - atan_lut(i);
				end
			end
		end
	end

	// Result keeps the gain K of about 1.6468 and the caller must leave headroom for it
	assign xout = x[stages][width-1:0];
	assign yout = y[stages][width-1:0];

endmodule

/* hw/coupling_regs.sv */
module coupling_regs (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 host_we,
	input  logic [host_pkg::host_addr_w-1:0]     host_addr,
	input  logic [host_pkg::host_data_w-1:0]     host_wdata,
	input  logic [host_pkg::host_addr_w-1:0]     host_rd_addr,
	output logic [host_pkg::host_data_w-1:0]     host_rdata,
	input  logic                                 coupling_addr,
	input  logic                                 offset_addr,
	output logic signed [couple_pkg::data_w-1:0] coupling,
	output logic [couple_pkg::phase_w-1:0]       phase_offset,
	output logic [couple_pkg::phase_w-1:0]       lo_step,
	output logic                                 lo_reset
);
	import couple_pkg::*;
	import host_pkg::*;

	// Coefficient storage holds one entry per interleave slot
	logic signed [data_w-1:0] coupling_r [0:1];
	logic [phase_w-1:0] offset_r [0:1];
	logic [phase_w-1:0] lo_step_r;

	reg_addr_t waddr;
	reg_addr_t raddr;

	assign waddr = reg_addr_t'(host_addr);
	assign raddr = reg_addr_t'(host_rd_addr);

	// Host writes land on the clock edge where host_we is high
	always_ff @(posedge clk) begin
		if (rst) begin
			coupling_r[0] <= '0;
			coupling_r[1] <= '0;
			offset_r[0] <= '0;
			offset_r[1] <= '0;
			lo_step_r <= '0;
			lo_reset <= 1'b0;
		end else begin
			// The LO clear is a single-cycle strobe whose data is ignored
			lo_reset <= host_we && (waddr == reg_lo_reset);
			if (host_we) begin
				case (waddr)
					reg_coupling_0: coupling_r[0] <= host_wdata[data_w-1:0];
					reg_coupling_1: coupling_r[1] <= host_wdata[data_w-1:0];
					reg_offset_0:   offset_r[0] <= host_wdata[phase_w-1:0];
					reg_offset_1:   offset_r[1] <= host_wdata[phase_w-1:0];
					reg_lo_step:    lo_step_r <= host_wdata[phase_w-1:0];
					default: ;
				endcase
			end
		end
	end

	// Coupler read ports answer in the same cycle
	assign coupling = coupling_r[coupling_addr];
	assign phase_offset = offset_r[offset_addr];
	assign lo_step = lo_step_r;

	// Host read port returns the couplings sign extended to the bus width
	always_comb begin
		case (raddr)
			reg_coupling_0: host_rdata = host_data_w'(coupling_r[0]);
			reg_coupling_1: host_rdata = host_data_w'(coupling_r[1]);
			reg_offset_0:   host_rdata = host_data_w'(offset_r[0]);
			reg_offset_1:   host_rdata = host_data_w'(offset_r[1]);
			reg_lo_step:    host_rdata = host_data_w'(lo_step_r);
			default:        host_rdata = '0;
		endcase
	end

	// Host software only ever writes addresses inside the register map
	a_write_addr: assert property (@(posedge clk) disable iff (rst)
		host_we |-> host_addr <= reg_lo_reset);

endmodule

/* hw/lo_phase_gen.sv */
module lo_phase_gen (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           iq,
	input  logic [couple_pkg::phase_w-1:0] lo_step,
	input  logic                           lo_reset,
	output logic [couple_pkg::phase_w-1:0] lo_phase
);
	import couple_pkg::*;

	iq_slot_t slot;

	assign slot = iq ? slot_i : slot_q;

	// Phase accumulator that wraps modulo one full turn
	// It steps on the edge that closes an I cycle, so one value serves a whole pair
	always_ff @(posedge clk) begin
		if (rst || lo_reset) begin
			lo_phase <= '0;
		end else if (slot == slot_i) begin
			lo_phase <= lo_phase + lo_step;
		end
	end

	// The interleave must toggle on every clock once the stream runs
	// A stuck iq would freeze the LO and pair the wrong drive halves downstream
	a_iq_alternates: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> iq != $past(iq));

	// The stream restarts on an I cycle after reset
	a_iq_starts_i: assert property (@(posedge clk)
		$fell(rst) |-> iq);

endmodule

/* hw/pair_couple.sv */
module pair_couple #(
	parameter int stages = 20,
	parameter int width = 18
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           iq,
	input  logic signed [width-1:0]        drive,
	input  logic [couple_pkg::phase_w-1:0] lo_phase,
	input  logic signed [width-1:0]        coupling,
	input  logic [couple_pkg::phase_w-1:0] phase_offset,
	output logic                           coupling_addr,
	output logic                           offset_addr,
	output logic signed [width:0]          pair
);
	import couple_pkg::*;

	iq_slot_t slot;

	assign slot = iq ? slot_i : slot_q;

	// The offset is fetched for the next cycle's slot
	// Registering the phase sum then lines it up with the coupling read this cycle
	assign coupling_addr = iq;
	assign offset_addr = ~iq;

	// Total phase of the selected slot
	logic [phase_w-1:0] out_phase;
	always_ff @(posedge clk) begin
		if (rst) begin
			out_phase <= '0;
		end else begin
			out_phase <= lo_phase + phase_offset;
		end
	end

	// Turn magnitude and phase into the coupling's Cartesian form
	logic signed [width-1:0] rot_x;
	logic signed [width-1:0] rot_y;

	cordic_rotator #(
		.stages(stages),
		.width(width)
	) u_cordic (
		.clk(clk),
		.rst(rst),
		.xin(coupling),
		.yin('0),
		.phasein(out_phase),
		.xout(rot_x),
		.yout(rot_y)
	);

	// Capture each I sample with the Q sample that follows it
	// The complex value then stays steady for two cycles
	logic signed [width-1:0] drive1;
	logic signed [width-1:0] d_real;
	logic signed [width-1:0] d_imag;
	always_ff @(posedge clk) begin
		if (rst) begin
			drive1 <= '0;
			d_real <= '0;
			d_imag <= '0;
		end else begin
			drive1 <= drive;
			if (slot == slot_q) begin
				d_real <= drive1;
				d_imag <= drive;
			end
		end
	end

	// Drive delay line that matches the phase register and the CORDIC depth
	logic signed [width-1:0] re_dly [0:stages];
	logic signed [width-1:0] im_dly [0:stages];
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k <= stages; k++) begin
				re_dly[k] <= '0;
				im_dly[k] <= '0;
			end
		end else begin
			re_dly[0] <= d_real;
			im_dly[0] <= d_imag;
			for (int k = 1; k <= stages; k++) begin
				re_dly[k] <= re_dly[k-1];
				im_dly[k] <= im_dly[k-1];
			end
		end
	end

	// Real part of the complex product is scaled back down by 2**(width-1)
	logic signed [2*width-1:0] prod_x;
	logic signed [2*width-1:0] prod_y;
	logic signed [width-1:0] prod_x2;
	logic signed [width-1:0] prod_y2;
	logic signed [width:0] out_sum;
	always_ff @(posedge clk) begin
		if (rst) begin
			prod_x <= '0;
			prod_y <= '0;
			prod_x2 <= '0;
			prod_y2 <= '0;
			out_sum <= '0;
		end else begin
			prod_x <= rot_x * re_dly[stages];
			prod_y <= rot_y * im_dly[stages];
			prod_x2 <= prod_x[2*width-2 -: width];
			prod_y2 <= prod_y[2*width-2 -: width];
			// One extra MSB goes forward instead of saturating
			out_sum <= (width+1)'(prod_x2) - (width+1)'(prod_y2);
		end
	end

	assign pair = out_sum;

	// The offset fetched last cycle belongs to the slot whose coupling is read now
	a_offset_aligned: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> $past(offset_addr) == coupling_addr);

endmodule

/* hw/couple_top.sv */
module couple_top (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  iq,
	input  logic signed [couple_pkg::data_w-1:0]  drive,
	input  logic                                  host_we,
	input  logic [host_pkg::host_addr_w-1:0]      host_addr,
	input  logic [host_pkg::host_data_w-1:0]      host_wdata,
	input  logic [host_pkg::host_addr_w-1:0]      host_rd_addr,
	output logic [host_pkg::host_data_w-1:0]      host_rdata,
	output logic signed [couple_pkg::pair_w-1:0]  pair
);
	import couple_pkg::*;

	// Coefficient read port between the coupler and the register bank
	logic coupling_addr;
	logic offset_addr;
	logic signed [data_w-1:0] coupling;
	logic [phase_w-1:0] phase_offset;

	// LO control and phase
	logic [phase_w-1:0] lo_step;
	logic lo_reset;
	logic [phase_w-1:0] lo_phase;

	coupling_regs u_regs (
		.clk(clk),
		.rst(rst),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_rd_addr(host_rd_addr),
		.host_rdata(host_rdata),
		.coupling_addr(coupling_addr),
		.offset_addr(offset_addr),
		.coupling(coupling),
		.phase_offset(phase_offset),
		.lo_step(lo_step),
		.lo_reset(lo_reset)
	);

	lo_phase_gen u_lo (
		.clk(clk),
		.rst(rst),
		.iq(iq),
		.lo_step(lo_step),
		.lo_reset(lo_reset),
		.lo_phase(lo_phase)
	);

	// Drive to pair takes cordic_stages+5 cycles
	pair_couple #(
		.stages(cordic_stages),
		.width(data_w)
	) u_couple (
		.clk(clk),
		.rst(rst),
		.iq(iq),
		.drive(drive),
		.lo_phase(lo_phase),
		.coupling(coupling),
		.phase_offset(phase_offset),
		.coupling_addr(coupling_addr),
		.offset_addr(offset_addr),
		.pair(pair)
	);

endmodule

/* test/couple_check.sv */
module couple_check (
	input  logic                                 clk,
	input  logic                                 iq,
	input  logic signed [couple_pkg::pair_w-1:0] pair,
	input  logic [host_pkg::host_data_w-1:0]     host_rdata,
	output int                                   value_errors,
	output int                                   timeout_errors
);
	timeunit 1ns;
	timeprecision 100ps;
	import couple_pkg::*;

	// CORDIC gain of the rotator, applied to the coupling magnitude
	localparam real k_gain = 1.6468;
	// Settle needs this many matching samples in a row
	localparam int settle_run = 8;
	localparam int settle_limit = 200;
	// Samples watched while the LO sweeps
	localparam int bound_samples = 120;

	initial begin
		value_errors = 0;
		timeout_errors = 0;
	end

	function automatic longint abs_val(input longint v);
		return (v < 0) ? -v : v;
	endfunction

	task automatic report_value(input string name, input longint exp, input longint act);
		value_errors++;
		$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
	endtask

	// Outputs are sampled on the falling edge, half a cycle after they change
	task automatic expect_rdata(input string name, input logic [host_pkg::host_data_w-1:0] exp);
		@(negedge clk);
		if (host_rdata !== exp) begin
			report_value(name, exp, host_rdata);
		end
	endtask

	task automatic expect_pair_zero(input int cycles);
		for (int n = 0; n < cycles; n++) begin
			@(negedge clk);
			if (pair !== '0) begin
				report_value("pair", 0, pair);
			end
		end
	endtask

	// At the falling edge iq names the slot that the current pair value belongs to
	task automatic settle(input longint exp_i, input longint exp_q, input longint tol);
		int run;
		int waited;
		longint exp;
		run = 0;
		waited = 0;
		exp = exp_i;
		while (run < settle_run && waited < settle_limit) begin
			@(negedge clk);
			waited++;
			exp = iq ? exp_i : exp_q;
			if (!$isunknown(pair) && abs_val(pair - exp) <= tol) begin
				run++;
			end else begin
				run = 0;
			end
		end
		if (run < settle_run) begin
			timeout_errors++;
			$display("Timeout: pair did not settle to the expected values in %0d cycles",
				settle_limit);
			report_value(iq ? "pair (I slot)" : "pair (Q slot)", exp, pair);
		end
	endtask

	// With the LO running each slot must stay inside K*|coupling|*|drive|/2**17
	task automatic check_bound(input longint c_i, input longint c_q, input longint d_i,
			input longint d_q, input longint tol);
		real mag;
		real bnd_i;
		real bnd_q;
		real bnd;
		longint val;
		longint peak_i;
		mag = $sqrt(1.0 * d_i * d_i + 1.0 * d_q * d_q);
		bnd_i = k_gain * abs_val(c_i) * mag / (2.0 ** (data_w - 1)) + tol;
		bnd_q = k_gain * abs_val(c_q) * mag / (2.0 ** (data_w - 1)) + tol;
		peak_i = 0;
		// Samples of the old setting leave the pipeline after stages+5 cycles
		repeat (cordic_stages + 6) @(negedge clk);
		for (int n = 0; n < bound_samples; n++) begin
			@(negedge clk);
			bnd = iq ? bnd_i : bnd_q;
			val = pair;
			if ($isunknown(pair) || abs_val(val) > bnd) begin
				value_errors++;
				$display("[FAIL] t=%0t pair expected magnitude at most %0d got %0d",
					$time, longint'(bnd), val);
			end
			if (iq && abs_val(val) > peak_i) begin
				peak_i = abs_val(val);
			end
		end
		// A sweep over more than a turn should come close to the bound
		if (peak_i < (bnd_i - tol) / 2) begin
			value_errors++;
			$display("The I slot peak of %0d stayed far below its bound while the LO swept",
				peak_i);
		end
	endtask

endmodule

/* test/couple_tb.sv */
module couple_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import couple_pkg::*;
	import host_pkg::*;

	// Words per test vector in the data file
	localparam int cols = 10;
	localparam int max_vectors = 32;

	logic clk;
	logic rst;
	logic iq;
	logic signed [data_w-1:0] drive;
	logic host_we;
	logic [host_addr_w-1:0] host_addr;
	logic [host_data_w-1:0] host_wdata;
	logic [host_addr_w-1:0] host_rd_addr;
	logic [host_data_w-1:0] host_rdata;
	logic signed [pair_w-1:0] pair;

	// Drive values for the I and Q halves of the stream
	logic signed [data_w-1:0] cur_i;
	logic signed [data_w-1:0] cur_q;
	logic [31:0] vec_mem [0:cols*max_vectors-1];
	int value_errors;
	int timeout_errors;
	int seed;

	couple_top DUT (
		.clk(clk),
		.rst(rst),
		.iq(iq),
		.drive(drive),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_rd_addr(host_rd_addr),
		.host_rdata(host_rdata),
		.pair(pair)
	);

	couple_check u_check (
		.clk(clk),
		.iq(iq),
		.pair(pair),
		.host_rdata(host_rdata),
		.value_errors(value_errors),
		.timeout_errors(timeout_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// The stream holds an I cycle during reset and then alternates every clock
	always @(posedge clk) begin
		if (rst) begin
			iq <= 1'b1;
			drive <= cur_i;
		end else begin
			iq <= ~iq;
			drive <= iq ? cur_q : cur_i;
		end
	end

	function automatic longint to_signed(input logic [31:0] word);
		return longint'(signed'(word));
	endfunction

	// The register bank takes the write on the second edge
	task automatic write_reg(input reg_addr_t addr, input logic [host_data_w-1:0] data);
		@(posedge clk);
		host_we <= 1'b1;
		host_addr <= addr;
		host_wdata <= data;
		@(posedge clk);
		host_we <= 1'b0;
	endtask

	task automatic read_back(input reg_addr_t addr, input logic [host_data_w-1:0] exp);
		@(posedge clk);
		host_rd_addr <= addr;
		u_check.expect_rdata($sformatf("host_rdata[%0d]", addr), exp);
	endtask

	// Each vector holds coupling_0 coupling_1 offset_0 offset_1 lo_step drive_i drive_q
	// exp_i exp_q and tol in that order
	// Coupling 1 and offset 1 serve the I slot
	task automatic run_vector(input int n);
		int base;
		base = n * cols;
		write_reg(reg_coupling_0, host_data_w'(vec_mem[base]));
		write_reg(reg_coupling_1, host_data_w'(vec_mem[base+1]));
		write_reg(reg_offset_0, host_data_w'(vec_mem[base+2]));
		write_reg(reg_offset_1, host_data_w'(vec_mem[base+3]));
		write_reg(reg_lo_step, host_data_w'(vec_mem[base+4]));
		write_reg(reg_lo_reset, '0);
		cur_i <= data_w'(vec_mem[base+5]);
		cur_q <= data_w'(vec_mem[base+6]);
		if (vec_mem[base+4] == 0) begin
			u_check.settle(to_signed(vec_mem[base+7]), to_signed(vec_mem[base+8]),
				to_signed(vec_mem[base+9]));
		end else begin
			u_check.check_bound(to_signed(vec_mem[base+1]), to_signed(vec_mem[base]),
				to_signed(vec_mem[base+5]), to_signed(vec_mem[base+6]),
				to_signed(vec_mem[base+9]));
		end
	endtask

	initial begin
		logic [host_data_w-1:0] rnd;
		int n;
		int setup_errors;
		seed = 31497;
		setup_errors = 0;
		rst = 1'b1;
		iq = 1'b1;
		drive = '0;
		cur_i = '0;
		cur_q = '0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		host_rd_addr = '0;
		$readmemh("test/couple_tests.dat", vec_mem);
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// Everything reads zero straight after reset
		u_check.expect_pair_zero(4);
		for (int a = 0; a < 6; a++) begin
			read_back(reg_addr_t'(a), '0);
		end

		// Random register contents keep the couplings as sign-extended 18-bit values
		for (int a = 0; a < 5; a++) begin
			rnd = host_data_w'($random(seed));
			if (a < 2) begin
				rnd = {rnd[data_w-1], rnd[data_w-1:0]};
			end
			write_reg(reg_addr_t'(a), rnd);
			read_back(reg_addr_t'(a), rnd);
		end

		// The vector list ends at the first word that the file left unset
		n = 0;
		while (n < max_vectors && !$isunknown(vec_mem[n*cols])) begin
			run_vector(n);
			n++;
		end
		if (n == 0) begin
			setup_errors++;
			$display("No test vectors could be read from test/couple_tests.dat");
		end

		$display("Error count: %0d value, %0d timeout, %0d setup",
			value_errors, timeout_errors, setup_errors);
		if (value_errors == 0 && timeout_errors == 0 && setup_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* pair_couple_sys.f */
hw/couple_pkg.sv
hw/host_pkg.sv
hw/cordic_rotator.sv
hw/coupling_regs.sv
hw/lo_phase_gen.sv
hw/pair_couple.sv
hw/couple_top.sv
test/couple_check.sv
test/couple_tb.sv

/* test/couple_tests.dat */
// Columns: coupling_0 coupling_1 offset_0 offset_1 lo_step drive_i drive_q exp_i exp_q tol
// 32-bit two's complement hex, one vector per line, phase 0x80000 is one full turn
// Zero offsets, the two slots differ only in coupling
00008000 00010000 00000000 00000000 00000000 00009C40 FFFFB1E0 000080A7 00004054 00000020
00010000 00010000 00000000 00000000 00000000 FFFF3CB0 00007530 FFFF5F2F FFFF5F2F 00000020
// Quarter turn on the I slot, then on the Q slot
00010000 00010000 00000000 00020000 00000000 00009C40 FFFFB1E0 00004054 000080A7 00000020
00010000 00010000 00020000 00000000 00000000 00002710 000061A8 0000202A FFFFAF97 00000020
// Negative coupling on the I slot
00010000 FFFF0000 00000000 00000000 00000000 00009C40 FFFFB1E0 FFFF7F59 000080A7 00000020
// Eighth turn on both slots, then half turn on the I slot
00010000 00010000 00010000 00010000 00000000 00009C40 00004E20 00002D7C 00002D7C 00000020
00010000 00010000 00000000 00040000 00000000 00004E20 00001388 FFFFBFAC 00004054 00000020
// LO sweep, expected columns unused and only the amplitude bound applies
00010000 00008000 00000000 00000000 00004000 00007530 FFFF63C0 00000000 00000000 00000020
// First vector again once the LO has been stopped and cleared
00008000 00010000 00000000 00000000 00000000 00009C40 FFFFB1E0 000080A7 00004054 00000020
